/* hw/tia_defs.svh */
// TIA shared constants
`ifndef TIA_DEFS_SVH
`define TIA_DEFS_SVH

`define TIA_LINE_CLKS    228  // Clocks per scan line
`define TIA_VIS_W        160  // Visible pixels per line
`define TIA_FRAME_LINES  262  // NTSC lines per frame
`define TIA_FIRST_LINE   22   // First line that emits pixels
`define TIA_PICTURE_LINE 38   // First line with real colour
`define TIA_RES_OFFSET   5    // RESPx/RESBL position skew
`define TIA_AUD_DIV      38   // Base audio divider

// Write addresses
`define TIA_A_VSYNC  6'h00
`define TIA_A_WSYNC  6'h02
`define TIA_A_COLUP0 6'h06
`define TIA_A_COLUP1 6'h07
`define TIA_A_COLUPF 6'h08
`define TIA_A_COLUBK 6'h09
`define TIA_A_CTRLPF 6'h0a
`define TIA_A_REFP0  6'h0b
`define TIA_A_REFP1  6'h0c
`define TIA_A_PF0    6'h0d
`define TIA_A_PF1    6'h0e
`define TIA_A_PF2    6'h0f
`define TIA_A_RESP0  6'h10
`define TIA_A_RESP1  6'h11
`define TIA_A_RESBL  6'h14
`define TIA_A_AUDC0  6'h15
`define TIA_A_AUDC1  6'h16
`define TIA_A_AUDF0  6'h17
`define TIA_A_AUDF1  6'h18
`define TIA_A_AUDV0  6'h19
`define TIA_A_AUDV1  6'h1a
`define TIA_A_GRP0   6'h1b
`define TIA_A_GRP1   6'h1c
`define TIA_A_ENABL  6'h1f
`define TIA_A_CXCLR  6'h2c

// Read addresses
`define TIA_R_CXP0FB 6'h02
`define TIA_R_CXP1FB 6'h03
`define TIA_R_CXBLPF 6'h06
`define TIA_R_CXPPMM 6'h07

`endif

/* hw/tia_pkg.sv */
// TIA shared types
`default_nettype none

package tia_pkg;

  typedef struct packed {
    logic       stb;  // Access strobe
    logic       we;   // Write when set, read otherwise
    logic [5:0] adr;
    logic [7:0] dat;
  } bus_req_t;

  typedef struct packed {
    logic [7:0] x;  // Clock within line, 0..227
    logic [8:0] y;  // Line within frame, 0..261
  } beam_t;

  typedef struct packed {
    logic [6:0]  colup0;
    logic [6:0]  colup1;
    logic [6:0]  colupf;
    logic [6:0]  colubk;
    logic [19:0] pf;           // PF0..PF2 in scan order
    logic        refpf;
    logic        scorepf;
    logic        pf_priority;  // Playfield above players
    logic        enabl;
    logic [3:0]  ball_w;
    logic [7:0]  x_bl;
    logic [7:0]  grp0;
    logic [7:0]  grp1;
    logic        refp0;
    logic        refp1;
    logic [7:0]  x_p0;
    logic [7:0]  x_p1;
  } video_regs_t;

  typedef struct packed {
    logic [3:0] audc0;
    logic [3:0] audc1;
    logic [4:0] audf0;
    logic [4:0] audf1;
    logic [3:0] audv0;
    logic [3:0] audv1;
  } audio_regs_t;

  typedef struct packed {
    logic pf;
    logic bl;
    logic p0;
    logic p1;
  } obj_bits_t;

endpackage

`default_nettype wire

/* hw/tia_regs.sv */
// TIA write register file
`timescale 1ns/1ps
`default_nettype none
`include "tia_defs.svh"

module tia_regs (
  input  wire                  clk,
  input  wire                  reset,
  input  tia_pkg::bus_req_t    req_i,
  input  tia_pkg::beam_t       beam_i,
  output tia_pkg::video_regs_t vregs_o,
  output tia_pkg::audio_regs_t aregs_o,
  output logic                 vsync_restart_o,
  output logic                 stall_o
);

  logic       wr;
  logic       vsync_q;  // Last VSYNC bit 1
  logic [7:0] res_pos;  // Position for a RESxx strobe now

  assign wr = req_i.stb && req_i.we;
  assign res_pos = (beam_i.x >= 8'(`TIA_VIS_W)) ? 8'd0 : beam_i.x + 8'(`TIA_RES_OFFSET);

  // Rising VSYNC restarts the beam on this very edge
  assign vsync_restart_o = wr && (req_i.adr == `TIA_A_VSYNC) && req_i.dat[1] && !vsync_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      vregs_o <= '0;
      aregs_o <= '0;
      vsync_q <= 1'b0;
      stall_o <= 1'b0;
    end else begin
      if (beam_i.x == 8'(`TIA_VIS_W)) stall_o <= 1'b0;  // Release at hsync
      if (wr) begin
        case (req_i.adr)
          `TIA_A_VSYNC:  vsync_q <= req_i.dat[1];
          `TIA_A_WSYNC:  stall_o <= 1'b1;  // Overrides release
          `TIA_A_COLUP0: vregs_o.colup0 <= req_i.dat[7:1];
          `TIA_A_COLUP1: vregs_o.colup1 <= req_i.dat[7:1];
          `TIA_A_COLUPF: vregs_o.colupf <= req_i.dat[7:1];
          `TIA_A_COLUBK: vregs_o.colubk <= req_i.dat[7:1];
          `TIA_A_CTRLPF: begin
            vregs_o.refpf       <= req_i.dat[0];
            vregs_o.scorepf     <= req_i.dat[1];
            vregs_o.pf_priority <= req_i.dat[2];
            vregs_o.ball_w      <= 4'd1 << req_i.dat[5:4];
          end
          `TIA_A_REFP0:  vregs_o.refp0 <= req_i.dat[3];
          `TIA_A_REFP1:  vregs_o.refp1 <= req_i.dat[3];
          `TIA_A_PF0:    for (int i = 0; i < 4; i++) vregs_o.pf[i] <= req_i.dat[4 + i];
          `TIA_A_PF1:    for (int i = 0; i < 8; i++) vregs_o.pf[4 + i] <= req_i.dat[7 - i];
          `TIA_A_PF2:    vregs_o.pf[19:12] <= req_i.dat;  // Already LSB first
          `TIA_A_RESP0:  vregs_o.x_p0 <= res_pos;
          `TIA_A_RESP1:  vregs_o.x_p1 <= res_pos;
          `TIA_A_RESBL:  vregs_o.x_bl <= res_pos;
          `TIA_A_AUDC0:  aregs_o.audc0 <= req_i.dat[3:0];
          `TIA_A_AUDC1:  aregs_o.audc1 <= req_i.dat[3:0];
          `TIA_A_AUDF0:  aregs_o.audf0 <= req_i.dat[4:0];
          `TIA_A_AUDF1:  aregs_o.audf1 <= req_i.dat[4:0];
          `TIA_A_AUDV0:  aregs_o.audv0 <= req_i.dat[3:0];
          `TIA_A_AUDV1:  aregs_o.audv1 <= req_i.dat[3:0];
          `TIA_A_GRP0:   vregs_o.grp0 <= req_i.dat;
          `TIA_A_GRP1:   vregs_o.grp1 <= req_i.dat;
          `TIA_A_ENABL:  vregs_o.enabl <= req_i.dat[1];
          default: ;  // CXCLR and unused addresses
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* hw/tia_beam.sv */
// TIA beam position counters
`timescale 1ns/1ps
`default_nettype none
`include "tia_defs.svh"

module tia_beam (
  input  wire            clk,
  input  wire            reset,
  input  wire            restart_i,
  output tia_pkg::beam_t beam_o
);

  logic line_end;
  logic frame_end;

  assign line_end  = (beam_o.x == 8'(`TIA_LINE_CLKS - 1));
  assign frame_end = (beam_o.y == 9'(`TIA_FRAME_LINES - 1));

  always_ff @(posedge clk) begin
    if (reset || restart_i) begin
      beam_o <= '0;  // VSYNC puts the beam at top left
    end else if (line_end) begin
      beam_o.x <= 8'd0;
      if (frame_end) begin
        beam_o.y <= 9'd0;
      end else begin
        beam_o.y <= beam_o.y + 9'd1;
      end
    end else begin
      beam_o.x <= beam_o.x + 8'd1;
    end
  end

endmodule

`default_nettype wire

/* hw/tia_objects.sv */
// TIA object pixel generation
`timescale 1ns/1ps
`default_nettype none
`include "tia_defs.svh"

module tia_objects (
  input  tia_pkg::beam_t       beam_i,
  input  tia_pkg::video_regs_t vregs_i,
  output tia_pkg::obj_bits_t   bits_o
);

  logic       visible;
  logic [7:0] pf_col;   // Column within the 80-pixel half
  logic [8:0] bl_end;
  logic       pf_hit;
  logic       bl_hit;

  // One 8-pixel player, MSB at the left edge unless reflected
  function automatic logic player_bit(input logic [7:0] x, input logic [7:0] pos,
                                      input logic [7:0] grp, input logic refl);
    logic [8:0] off;
    off = {1'b0, x} - {1'b0, pos};
    if (x < pos || off >= 9'd8) return 1'b0;
    return refl ? grp[off[2:0]] : grp[3'd7 - off[2:0]];
  endfunction

  assign visible = (beam_i.x < 8'(`TIA_VIS_W));

  always_comb begin
    if (beam_i.x < 8'd80) begin
      pf_col = beam_i.x;
    end else if (vregs_i.refpf) begin
      pf_col = 8'd159 - beam_i.x;  // Mirrored right half
    end else begin
      pf_col = beam_i.x - 8'd80;
    end
  end

  assign pf_hit = vregs_i.pf[pf_col[6:2]];
  assign bl_end = {1'b0, vregs_i.x_bl} + {5'd0, vregs_i.ball_w};
  assign bl_hit = vregs_i.enabl && (beam_i.x >= vregs_i.x_bl) && ({1'b0, beam_i.x} < bl_end);

  assign bits_o.pf = visible && pf_hit;
  assign bits_o.bl = visible && bl_hit;
  assign bits_o.p0 = visible &&
                     player_bit(beam_i.x, vregs_i.x_p0, vregs_i.grp0, vregs_i.refp0);
  assign bits_o.p1 = visible &&
                     player_bit(beam_i.x, vregs_i.x_p1, vregs_i.grp1, vregs_i.refp1);

endmodule

`default_nettype wire

/* hw/tia_collide.sv */
// TIA collision latches
`timescale 1ns/1ps
`default_nettype none
`include "tia_defs.svh"

module tia_collide (
  input  wire                clk,
  input  wire                reset,
  input  tia_pkg::bus_req_t  req_i,
  input  tia_pkg::obj_bits_t bits_i,
  output logic [7:0]         dat_o
);

  // Latch order: p0-pf, p0-bl, p1-pf, p1-bl, bl-pf, p0-p1
  logic [5:0] cx;
  logic [5:0] hits;
  logic       clr;
  logic       rd;

  assign hits = {bits_i.p0 && bits_i.pf, bits_i.p0 && bits_i.bl,
                 bits_i.p1 && bits_i.pf, bits_i.p1 && bits_i.bl,
                 bits_i.bl && bits_i.pf, bits_i.p0 && bits_i.p1};
  assign clr  = req_i.stb && req_i.we && (req_i.adr == `TIA_A_CXCLR);
  assign rd   = req_i.stb && !req_i.we;

  always_ff @(posedge clk) begin
    if (reset || clr) begin
      cx <= '0;  // Clear beats a same-cycle hit
    end else begin
      cx <= cx | hits;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      dat_o <= 8'd0;
    end else if (rd) begin
      case (req_i.adr)
        `TIA_R_CXP0FB: dat_o <= {cx[5:4], 6'd0};
        `TIA_R_CXP1FB: dat_o <= {cx[3:2], 6'd0};
        `TIA_R_CXBLPF: dat_o <= {cx[1], 7'd0};
        `TIA_R_CXPPMM: dat_o <= {cx[0], 7'd0};  // No missiles, bit 6 stays 0
        default:       dat_o <= 8'd0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/tia_mixer.sv */
// TIA colour priority mixer
`timescale 1ns/1ps
`default_nettype none
`include "tia_defs.svh"

module tia_mixer (
  input  wire                  clk,
  input  wire                  reset,
  input  tia_pkg::beam_t       beam_i,
  input  tia_pkg::video_regs_t vregs_i,
  input  tia_pkg::obj_bits_t   bits_i,
  output logic [6:0]           vid_out_o,
  output logic [7:0]           vid_xpos_o,
  output logic [8:0]           vid_line_o,
  output logic                 vid_wr_o
);

  logic [6:0] pf_color;
  logic [6:0] color;

  // Score mode paints each half with its player colour
  assign pf_color = !vregs_i.scorepf ? vregs_i.colupf :
                    (beam_i.x < 8'd80) ? vregs_i.colup0 : vregs_i.colup1;

  always_comb begin
    if (beam_i.y < 9'(`TIA_PICTURE_LINE)) color = 7'd0;  // Blank top lines
    else if (bits_i.bl)                            color = vregs_i.colupf;
    else if (vregs_i.pf_priority && bits_i.pf)     color = pf_color;
    else if (bits_i.p0)                            color = vregs_i.colup0;
    else if (bits_i.p1)                            color = vregs_i.colup1;
    else if (bits_i.pf)                            color = pf_color;
    else                                           color = vregs_i.colubk;
  end

  always_ff @(posedge clk) begin
    if (reset) vid_wr_o <= 1'b0;
    else vid_wr_o <= (beam_i.y >= 9'(`TIA_FIRST_LINE)) && (beam_i.x < 8'(`TIA_VIS_W));
    vid_out_o  <= color;
    vid_xpos_o <= beam_i.x;
    vid_line_o <= beam_i.y;
  end

endmodule

`default_nettype wire

/* hw/tia_audio.sv */
// TIA tone generators
`timescale 1ns/1ps
`default_nettype none
`include "tia_defs.svh"

module tia_audio (
  input  wire                  clk,
  input  wire                  reset,
  input  tia_pkg::audio_regs_t aregs_i,
  output logic [3:0]           audio_left_o,
  output logic [3:0]           audio_right_o
);

  logic [1:0][3:0]  audc;
  logic [1:0][10:0] div;   // (AUDF+1) * 38, at most 1216
  logic [1:0][10:0] cnt;
  logic [1:0]       tone;

  assign audc   = {aregs_i.audc1, aregs_i.audc0};
  assign div[0] = (11'(aregs_i.audf0) + 11'd1) * 11'(`TIA_AUD_DIV);
  assign div[1] = (11'(aregs_i.audf1) + 11'd1) * 11'(`TIA_AUD_DIV);

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt  <= '0;
      tone <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (audc[i] == 4'd0) begin
          tone[i] <= 1'b1;  // AUDC 0 means steady volume
          cnt[i]  <= cnt[i] + 11'd1;
        end else if (cnt[i] >= div[i]) begin
          tone[i] <= !tone[i];
          cnt[i]  <= 11'd0;
        end else begin
          cnt[i]  <= cnt[i] + 11'd1;
        end
      end
    end
  end

  assign audio_left_o  = tone[0] ? aregs_i.audv0 : 4'd0;
  assign audio_right_o = tone[1] ? aregs_i.audv1 : 4'd0;

endmodule

`default_nettype wire

/* hw/tia_top.sv */
// TIA top level
`timescale 1ns/1ps
`default_nettype none

module tia_top (
  input  wire        clk,
  input  wire        reset,
  input  wire        stb_i,
  input  wire        we_i,
  input  wire  [5:0] adr_i,
  input  wire  [7:0] dat_i,
  output logic [7:0] dat_o,
  output logic       stall_o,
  output logic [6:0] vid_out_o,
  output logic [7:0] vid_xpos_o,
  output logic [8:0] vid_line_o,
  output logic       vid_wr_o,
  output logic [3:0] audio_left_o,
  output logic [3:0] audio_right_o
);

  tia_pkg::bus_req_t    req;
  tia_pkg::beam_t       beam;
  tia_pkg::video_regs_t vregs;
  tia_pkg::audio_regs_t aregs;
  tia_pkg::obj_bits_t   bits;
  logic                 restart;

  assign req = '{stb: stb_i, we: we_i, adr: adr_i, dat: dat_i};

  tia_regs u_regs (
    .clk(clk), .reset(reset), .req_i(req), .beam_i(beam),
    .vregs_o(vregs), .aregs_o(aregs), .vsync_restart_o(restart), .stall_o(stall_o)
  );

  tia_beam u_beam (
    .clk(clk), .reset(reset), .restart_i(restart), .beam_o(beam)
  );

  tia_objects u_objects (
    .beam_i(beam), .vregs_i(vregs), .bits_o(bits)
  );

  tia_collide u_collide (
    .clk(clk), .reset(reset), .req_i(req), .bits_i(bits), .dat_o(dat_o)
  );

  tia_mixer u_mixer (
    .clk(clk), .reset(reset), .beam_i(beam), .vregs_i(vregs), .bits_i(bits),
    .vid_out_o(vid_out_o), .vid_xpos_o(vid_xpos_o), .vid_line_o(vid_line_o),
    .vid_wr_o(vid_wr_o)
  );

  tia_audio u_audio (
    .clk(clk), .reset(reset), .aregs_i(aregs),
    .audio_left_o(audio_left_o), .audio_right_o(audio_right_o)
  );

endmodule

`default_nettype wire

/* tests/tia_model.svh */
// TIA reference model
`ifndef TIA_MODEL_SVH
`define TIA_MODEL_SVH

typedef struct packed {
  logic [6:0]  col_p0;
  logic [6:0]  col_p1;
  logic [6:0]  col_pf;
  logic [6:0]  col_bk;
  logic [19:0] pf;       // Bit n covers columns 4n..4n+3 of a half
  logic        pf_refl;
  logic        score;
  logic        pf_prio;
  logic        bl_on;
  logic [3:0]  bl_w;
  logic [7:0]  pos_bl;
  logic [7:0]  gr0;
  logic [7:0]  gr1;
  logic        refl0;
  logic        refl1;
  logic [7:0]  pos_p0;
  logic [7:0]  pos_p1;
  logic        vs_q;
  logic        stall;
  logic [5:0]  cx;       // p0-pf p0-bl p1-pf p1-bl bl-pf p0-p1
} model_state_t;

model_state_t st;
int           mx;        // Beam x
int           my;        // Beam y
logic         exp_wr;
int           exp_xpos;
int           exp_line;
logic [6:0]   exp_out;
logic [7:0]   exp_dat;

task automatic model_reset();
  st       = '0;
  mx       = 0;
  my       = 0;
  exp_wr   = 1'b0;
  exp_xpos = 0;
  exp_line = 0;
  exp_out  = 7'd0;
  exp_dat  = 8'd0;
endtask

// Object bits {pf, bl, p0, p1} at column x
function automatic logic [3:0] obj_at(input int x);
  int   col;
  int   off0;
  int   off1;
  logic pf;
  logic bl;
  logic p0;
  logic p1;
  if (x >= `TIA_VIS_W) return 4'b0000;
  col  = (x < 80) ? x : (st.pf_refl ? 159 - x : x - 80);
  off0 = x - int'(st.pos_p0);
  off1 = x - int'(st.pos_p1);
  pf   = st.pf[5'(col / 4)];
  bl   = st.bl_on && (x >= int'(st.pos_bl)) && (x < int'(st.pos_bl) + int'(st.bl_w));
  p0   = (off0 >= 0 && off0 < 8) ? st.gr0[3'(st.refl0 ? off0 : 7 - off0)] : 1'b0;
  p1   = (off1 >= 0 && off1 < 8) ? st.gr1[3'(st.refl1 ? off1 : 7 - off1)] : 1'b0;
  return {pf, bl, p0, p1};
endfunction

function automatic logic [6:0] colour_at(input int x, input int y, input logic [3:0] b);
  logic [6:0] pfc;
  pfc = !st.score ? st.col_pf : ((x < 80) ? st.col_p0 : st.col_p1);
  if (y < `TIA_PICTURE_LINE) return 7'd0;
  if (b[2]) return st.col_pf;             // Ball on top
  if (st.pf_prio && b[3]) return pfc;
  if (b[1]) return st.col_p0;
  if (b[0]) return st.col_p1;
  if (b[3]) return pfc;
  return st.col_bk;
endfunction

// One clock edge with the given bus request
task automatic model_step(input logic s, input logic w, input logic [5:0] a,
                          input logic [7:0] d);
  logic [3:0] b;
  logic       wr;
  logic [7:0] res;
  b        = obj_at(mx);
  wr       = s && w;
  res      = (mx >= `TIA_VIS_W) ? 8'd0 : 8'(mx + `TIA_RES_OFFSET);
  exp_wr   = (my >= `TIA_FIRST_LINE) && (mx < `TIA_VIS_W);
  exp_xpos = mx;
  exp_line = my;
  exp_out  = colour_at(mx, my, b);
  if (s && !w) begin
    case (a)
      `TIA_R_CXP0FB: exp_dat = {st.cx[5:4], 6'd0};
      `TIA_R_CXP1FB: exp_dat = {st.cx[3:2], 6'd0};
      `TIA_R_CXBLPF: exp_dat = {st.cx[1], 7'd0};
      `TIA_R_CXPPMM: exp_dat = {st.cx[0], 7'd0};
      default:       exp_dat = 8'd0;
    endcase
  end
  if (wr && a == `TIA_A_CXCLR) st.cx = 6'd0;  // Clear wins
  else st.cx = st.cx | {b[1] & b[3], b[1] & b[2], b[0] & b[3], b[0] & b[2],
                        b[2] & b[3], b[1] & b[0]};
  if (mx == `TIA_VIS_W) st.stall = 1'b0;
  if (wr && a == `TIA_A_WSYNC) st.stall = 1'b1;
  if (wr && a == `TIA_A_VSYNC && d[1] && !st.vs_q) begin
    mx = 0;
    my = 0;
  end else if (mx == `TIA_LINE_CLKS - 1) begin
    mx = 0;
    my = (my == `TIA_FRAME_LINES - 1) ? 0 : my + 1;
  end else begin
    mx = mx + 1;
  end
  if (wr) begin
    case (a)
      `TIA_A_VSYNC:  st.vs_q = d[1];
      `TIA_A_COLUP0: st.col_p0 = d[7:1];
      `TIA_A_COLUP1: st.col_p1 = d[7:1];
      `TIA_A_COLUPF: st.col_pf = d[7:1];
      `TIA_A_COLUBK: st.col_bk = d[7:1];
      `TIA_A_CTRLPF: begin
        st.pf_refl = d[0];
        st.score   = d[1];
        st.pf_prio = d[2];
        st.bl_w    = 4'd1 << d[5:4];
      end
      `TIA_A_REFP0:  st.refl0 = d[3];
      `TIA_A_REFP1:  st.refl1 = d[3];
      `TIA_A_PF0:    st.pf[3:0] = d[7:4];
      `TIA_A_PF1:    st.pf[11:4] = {<<{d}};  // Bit 7 drawn first
      `TIA_A_PF2:    st.pf[19:12] = d;
      `TIA_A_RESP0:  st.pos_p0 = res;
      `TIA_A_RESP1:  st.pos_p1 = res;
      `TIA_A_RESBL:  st.pos_bl = res;
      `TIA_A_GRP0:   st.gr0 = d;
      `TIA_A_GRP1:   st.gr1 = d;
      `TIA_A_ENABL:  st.bl_on = d[1];
      default: ;
    endcase
  end
endtask

`endif

/* tests/tia_tb.sv */
// TIA testbench
`timescale 1ns/1ps
`default_nettype none
`include "tia_defs.svh"

module tia_tb;

  localparam int FRAME = `TIA_LINE_CLKS * `TIA_FRAME_LINES;
  localparam int LIMIT = 6 * FRAME + 8 * 500 + 2 * 9000 + 20000;  // All phases plus margin

  logic       clk;
  logic       reset;
  logic       stb;
  logic       we;
  logic [5:0] adr;
  logic [7:0] dat;
  logic [7:0] dat_o;
  logic       stall_o;
  logic [6:0] vid_out_o;
  logic [7:0] vid_xpos_o;
  logic [8:0] vid_line_o;
  logic       vid_wr_o;
  logic [3:0] audio_left_o;
  logic [3:0] audio_right_o;
  int         cycles = 0;
  string      test_name;

  `include "tia_model.svh"

  tia_top dut (
    .clk(clk), .reset(reset), .stb_i(stb), .we_i(we), .adr_i(adr), .dat_i(dat),
    .dat_o(dat_o), .stall_o(stall_o), .vid_out_o(vid_out_o), .vid_xpos_o(vid_xpos_o),
    .vid_line_o(vid_line_o), .vid_wr_o(vid_wr_o), .audio_left_o(audio_left_o),
    .audio_right_o(audio_right_o)
  );

  always #50 clk = ~clk;  // 100 ns period

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == LIMIT) begin
      $display("TEST FAIL");
      $fatal(1, "Timeout, the tests did not finish within %0d cycles", LIMIT);
    end
  end

  task automatic check(input string what, input int expected, input int actual);
    if (expected != actual) begin
      $display("Error in %s, %s: expected %0d, actual %0d", test_name, what, expected, actual);
      $display("TEST FAIL");
      $fatal(1, "Value mismatch");
    end
  endtask

  // Drive at the falling edge, then compare after the next rising edge
  task automatic tick(input logic s, input logic w, input logic [5:0] a, input logic [7:0] d);
    stb = s;
    we  = w;
    adr = a;
    dat = d;
    model_step(s, w, a, d);
    @(negedge clk);
    check("vid_wr", int'(exp_wr), int'(vid_wr_o));
    if (exp_wr) begin
      check("vid_xpos", exp_xpos, int'(vid_xpos_o));
      check("vid_line", exp_line, int'(vid_line_o));
      check("vid_out", int'(exp_out), int'(vid_out_o));
    end
    check("stall", int'(st.stall), int'(stall_o));
    check("dat_o", int'(exp_dat), int'(dat_o));
  endtask

  task automatic idle();
    tick(1'b0, 1'b0, 6'd0, 8'd0);
  endtask

  function automatic logic [5:0] random_draw_addr();
    logic [5:0] addrs [16];
    addrs = '{`TIA_A_COLUP0, `TIA_A_COLUP1, `TIA_A_COLUPF, `TIA_A_COLUBK, `TIA_A_CTRLPF,
              `TIA_A_REFP0, `TIA_A_REFP1, `TIA_A_PF0, `TIA_A_PF1, `TIA_A_PF2, `TIA_A_RESP0,
              `TIA_A_RESP1, `TIA_A_RESBL, `TIA_A_GRP0, `TIA_A_GRP1, `TIA_A_ENABL};
    return addrs[$urandom_range(15)];
  endfunction

  task automatic raster_test();
    int restart_at;
    int wr_count;
    restart_at = $urandom_range(2000, FRAME);
    wr_count   = 0;
    for (int n = 0; n < 2 * FRAME; n++) begin
      if (n == restart_at) tick(1'b1, 1'b1, `TIA_A_VSYNC, 8'h02);
      else if (n == restart_at + 1) tick(1'b1, 1'b1, `TIA_A_VSYNC, 8'h00);
      else idle();
      if (n > restart_at && n <= restart_at + FRAME && vid_wr_o) wr_count++;
    end
    check("pixels per frame", (`TIA_FRAME_LINES - `TIA_FIRST_LINE) * `TIA_VIS_W, wr_count);
  endtask

  task automatic random_frames(input int length);
    int r;
    for (int n = 0; n < length; n++) begin
      r = $urandom_range(31);
      if (r < 3) tick(1'b1, 1'b1, random_draw_addr(), 8'($urandom));
      else if (r == 3) tick(1'b1, 1'b0, 6'($urandom_range(7)), 8'd0);  // Any read address
      else idle();
    end
  endtask

  task automatic read_latches(input logic expect_clear);
    logic [5:0] addrs [4];
    addrs = '{`TIA_R_CXP0FB, `TIA_R_CXP1FB, `TIA_R_CXBLPF, `TIA_R_CXPPMM};
    foreach (addrs[i]) begin
      tick(1'b1, 1'b0, addrs[i], 8'd0);
      if (expect_clear) check("latch after CXCLR", 0, int'(dat_o));
    end
  endtask

  task automatic wsync_test();
    repeat (8) begin
      repeat ($urandom_range(227)) idle();
      tick(1'b1, 1'b1, `TIA_A_WSYNC, 8'd0);
      while (stall_o) idle();
    end
  endtask

  task automatic tone_test(input int ch);
    int         f;
    int         half;
    int         run;
    int         toggles;
    logic [3:0] vol;
    logic [3:0] prev;
    logic [3:0] now;
    f    = $urandom_range(31);
    vol  = 4'($urandom_range(15, 1));
    half = (f + 1) * `TIA_AUD_DIV + 1;
    tick(1'b1, 1'b1, `TIA_A_AUDF0 + 6'(ch), 8'(f));
    tick(1'b1, 1'b1, `TIA_A_AUDV0 + 6'(ch), 8'(vol));
    tick(1'b1, 1'b1, `TIA_A_AUDC0 + 6'(ch), 8'($urandom_range(15, 1)));
    prev    = (ch == 0) ? audio_left_o : audio_right_o;
    run     = 0;
    toggles = 0;
    while (toggles < 5) begin
      idle();
      now = (ch == 0) ? audio_left_o : audio_right_o;
      run++;
      if (now != prev) begin
        toggles++;
        check("tone level", int'((prev == vol) ? 4'd0 : vol), int'(now));
        if (toggles >= 3) check("tone half period", half, run);  // First interval is partial
        run  = 0;
        prev = now;
      end
    end
    tick(1'b1, 1'b1, `TIA_A_AUDC0 + 6'(ch), 8'd0);
    idle();
    repeat (2 * half) begin
      idle();
      check("steady level", int'(vol), int'((ch == 0) ? audio_left_o : audio_right_o));
    end
  endtask

  initial begin
    clk   = 1'b0;
    reset = 1'b1;
    stb   = 1'b0;
    we    = 1'b0;
    adr   = 6'd0;
    dat   = 8'd0;
    void'($urandom(32'h9052));
    model_reset();
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    test_name = "raster";
    raster_test();

    test_name = "pixel colour";
    random_frames(2 * FRAME);

    test_name = "collisions";
    repeat (2) begin
      random_frames(FRAME);
      read_latches(1'b0);
      while (mx != `TIA_VIS_W + 5) idle();  // No object bits past the visible area
      tick(1'b1, 1'b1, `TIA_A_CXCLR, 8'd0);
      read_latches(1'b1);
    end

    test_name = "wsync";
    wsync_test();

    test_name = "audio";
    tone_test(0);
    tone_test(1);

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+hw
+incdir+tests
hw/tia_pkg.sv
hw/tia_regs.sv
hw/tia_beam.sv
hw/tia_objects.sv
hw/tia_collide.sv
hw/tia_mixer.sv
hw/tia_audio.sv
hw/tia_top.sv
tests/tia_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tia_tb
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
FILELIST  ?= project.f

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard hw/*.svh tests/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
